//--- source/obi_mem_pkg.sv
// Shared OBI bus types, address map and PMA region table; imported by every subsystem module
`default_nettype none

package obi_mem_pkg;

    // ----------------------------------------------------------
    // Bus geometry
    // ----------------------------------------------------------

    // Byte address and data word widths of both OBI ports
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Word index bits used by the SRAM, taken from addr[13:2]
    localparam int MEM_IDX_W = 12;

    // ----------------------------------------------------------
    // Bus payloads
    // ----------------------------------------------------------

    // Address phase of one OBI transfer
    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic                we;
        // One enable per byte lane
        logic [DATA_W/8-1:0] be;
        logic [DATA_W-1:0]   wdata;
        // Set on instruction-port requests
        logic                fetch;
    } obi_req_t;

    // Response phase, presented together with rvalid
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } obi_rsp_t;

    // ----------------------------------------------------------
    // Physical memory attributes
    // ----------------------------------------------------------

    // One region, bounds are word addresses (addr[31:2]) and inclusive
    typedef struct packed {
        logic [ADDR_W-3:0] word_addr_low;
        logic [ADDR_W-3:0] word_addr_high;
        // Memory-like region, instruction fetch allowed
        logic              main;
    } pma_region_t;

    localparam int PMA_NUM_REGIONS = 3;

    // Region map
    //   code 0x0000_0000 .. 0x0000_0FFF  main
    //   data 0x0000_1000 .. 0x0000_1FFF  main
    //   io   0x0000_2000 .. 0x0000_20FF  not main
    localparam pma_region_t PMA_CFG [PMA_NUM_REGIONS] = '{
        '{word_addr_low:  30'h0000_0000,
          word_addr_high: 30'h0000_03FF,
          main:           1'b1},
        '{word_addr_low:  30'h0000_0400,
          word_addr_high: 30'h0000_07FF,
          main:           1'b1},
        '{word_addr_low:  30'h0000_0800,
          word_addr_high: 30'h0000_083F,
          main:           1'b0}
    };

endpackage : obi_mem_pkg

`default_nettype wire

//--- source/obi_port_arbiter.sv
// Round-robin merge of the instruction and data OBI ports onto one memory, with response steering
`timescale 1ns/100ps
`default_nettype none

module obi_port_arbiter
    import obi_mem_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,

    // Instruction port, request already tied off to a fetch
    input  wire logic     instr_req_i,
    input  wire obi_req_t instr_pkt_i,
    output logic          instr_gnt_o,

    // Data port
    input  wire logic     data_req_i,
    input  wire obi_req_t data_pkt_i,
    output logic          data_gnt_o,

    // Merged request towards the memory
    output obi_req_t      mem_req_o,
    output logic          mem_req_valid_o,

    // Memory response, one cycle after the grant
    input  wire logic     mem_rvalid_i,
    input  wire obi_rsp_t mem_rsp_i,

    // Steered responses
    output logic          instr_rvalid_o,
    output obi_rsp_t      instr_rsp_o,
    output logic          data_rvalid_o,
    output obi_rsp_t      data_rsp_o
);

    // High when the data port wins the next contested cycle
    logic prio_data_q;
    // Port that owns the response of the previous grant, 1 means instruction
    logic owner_instr_q;
    // Both ports request in this cycle
    logic contested;

    // ----------------------------------------------------------
    // Grant selection
    // ----------------------------------------------------------

    assign contested = instr_req_i & data_req_i;

    // Memory always accepts, so a lone request is granted at once
    assign data_gnt_o  = data_req_i & (~instr_req_i | prio_data_q);
    assign instr_gnt_o = instr_req_i & (~data_req_i | ~prio_data_q);

    // Any request produces exactly one grant
    assign mem_req_valid_o = instr_req_i | data_req_i;

    // Winner's request goes to memory, fetch follows the winning port
    always_comb begin
        if (instr_gnt_o) begin
            mem_req_o = instr_pkt_i;
        end else begin
            mem_req_o = data_pkt_i;
        end
        mem_req_o.fetch = instr_gnt_o;
    end

    // ----------------------------------------------------------
    // Round-robin and ownership state
    // ----------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // Data first after reset
            prio_data_q   <= 1'b1;
            owner_instr_q <= 1'b0;
        end else begin
            // Loser of a contested cycle gets priority next time
            if (contested) begin
                prio_data_q <= ~data_gnt_o;
            end
            // Remember who gets the response in the next cycle
            owner_instr_q <= instr_gnt_o;
        end
    end

    // ----------------------------------------------------------
    // Response steering
    // ----------------------------------------------------------

    // Payload shared, rvalid marks the owner
    assign instr_rvalid_o = mem_rvalid_i & owner_instr_q;
    assign data_rvalid_o  = mem_rvalid_i & ~owner_instr_q;
    assign instr_rsp_o    = mem_rsp_i;
    assign data_rsp_o     = mem_rsp_i;

endmodule : obi_port_arbiter

`default_nettype wire

//--- source/obi_pma_check.sv
// Combinational PMA lookup that allows or denies the access currently granted to memory
`timescale 1ns/100ps
`default_nettype none

module obi_pma_check
    import obi_mem_pkg::*;
(
    // Merged request from the arbiter
    input  wire obi_req_t mem_req_i,
    input  wire logic     mem_req_valid_i,

    // High when the access may touch memory
    output logic          pma_ok_o
);

    // Word address of the access, compared against region bounds
    logic [ADDR_W-3:0]          word_addr;
    // One hit bit per region
    logic [PMA_NUM_REGIONS-1:0] region_hit;
    // One permission bit per region for this access type
    logic [PMA_NUM_REGIONS-1:0] region_allow;

    assign word_addr = mem_req_i.addr[ADDR_W-1:2];

    // ----------------------------------------------------------
    // Region compare
    // ----------------------------------------------------------

    always_comb begin
        for (int r = 0; r < PMA_NUM_REGIONS; r++) begin
            // Inclusive bounds on both sides
            region_hit[r] = (word_addr >= PMA_CFG[r].word_addr_low) &&
                            (word_addr <= PMA_CFG[r].word_addr_high);

            // Loads and stores go anywhere mapped
            // fetch only from main regions
            region_allow[r] = region_hit[r] &
                              (~mem_req_i.fetch | PMA_CFG[r].main);
        end
    end

    // ----------------------------------------------------------
    // Decision
    // ----------------------------------------------------------

    // Unmapped addresses hit no region and are denied
    // regions do not overlap, so any allowing hit is enough
    assign pma_ok_o = mem_req_valid_i & (|region_allow);

endmodule : obi_pma_check

`default_nettype wire

//--- source/obi_sram.sv
// Single-port word SRAM with byte enables, answering each accepted access one cycle later
`timescale 1ns/100ps
`default_nettype none

module obi_sram
    import obi_mem_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,

    // Request side, always ready
    input  wire obi_req_t mem_req_i,
    input  wire logic     mem_req_valid_i,
    input  wire logic     pma_ok_i,

    // Response side, one cycle after acceptance
    output logic          mem_rvalid_o,
    output obi_rsp_t      mem_rsp_o
);

    localparam int MEM_WORDS = 2 ** MEM_IDX_W;

    // Storage array
    logic [DATA_W-1:0]    mem_q [MEM_WORDS];

    // Word index from addr[13:2]
    logic [MEM_IDX_W-1:0] word_idx;
    // Accepted and allowed accesses
    logic                 do_write;
    logic                 do_read;

    // Response registers
    logic [DATA_W-1:0]    rdata_q;
    logic                 rvalid_q;
    logic                 err_q;

    assign word_idx = mem_req_i.addr[MEM_IDX_W+1:2];
    assign do_write = pma_ok_i & mem_req_i.we;
    assign do_read  = pma_ok_i & ~mem_req_i.we;

    // ----------------------------------------------------------
    // Array and read data
    // ----------------------------------------------------------

    always_ff @(posedge clk_i) begin
        // Only enabled lanes are written
        if (do_write) begin
            for (int b = 0; b < DATA_W / 8; b++) begin
                if (mem_req_i.be[b]) begin
                    mem_q[word_idx][b*8 +: 8] <= mem_req_i.wdata[b*8 +: 8];
                end
            end
        end
        // Old contents on a same-cycle write
        // zero for writes and denied accesses
        if (do_read) begin
            rdata_q <= mem_q[word_idx];
        end else begin
            rdata_q <= '0;
        end
    end

    // ----------------------------------------------------------
    // Response control
    // ----------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            // Every accepted request answers, allowed or not
            rvalid_q <= mem_req_valid_i;
            err_q    <= mem_req_valid_i & ~pma_ok_i;
        end
    end

    assign mem_rvalid_o = rvalid_q;
    assign mem_rsp_o    = '{rdata: rdata_q, err: err_q};

endmodule : obi_sram

`default_nettype wire

//--- source/obi_mem_subsys.sv
// Top of the memory subsystem, connects both core OBI ports to the arbiter, PMA checker and SRAM
`timescale 1ns/100ps
`default_nettype none

module obi_mem_subsys
    import obi_mem_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,

    // Instruction OBI port, read only
    input  wire logic              instr_req_i,
    input  wire logic [ADDR_W-1:0] instr_addr_i,
    output logic                   instr_gnt_o,
    output logic                   instr_rvalid_o,
    output obi_rsp_t               instr_rsp_o,

    // Data OBI port
    input  wire logic              data_req_i,
    input  wire obi_req_t          data_req_pkt_i,
    output logic                   data_gnt_o,
    output logic                   data_rvalid_o,
    output obi_rsp_t               data_rsp_o
);

    // Full request built from the instruction address
    obi_req_t instr_pkt;

    // Merged memory side
    obi_req_t mem_req;
    logic     mem_req_valid;
    logic     pma_ok;
    logic     mem_rvalid;
    obi_rsp_t mem_rsp;

    // ----------------------------------------------------------
    // Instruction port tie-offs
    // ----------------------------------------------------------

    // Full-word reads only, never writes
    assign instr_pkt = '{addr:  instr_addr_i,
                         we:    1'b0,
                         be:    '1,
                         wdata: '0,
                         fetch: 1'b1};

    obi_port_arbiter u_arbiter (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .instr_req_i     (instr_req_i),
        .instr_pkt_i     (instr_pkt),
        .instr_gnt_o     (instr_gnt_o),
        .data_req_i      (data_req_i),
        .data_pkt_i      (data_req_pkt_i),
        .data_gnt_o      (data_gnt_o),
        .mem_req_o       (mem_req),
        .mem_req_valid_o (mem_req_valid),
        .mem_rvalid_i    (mem_rvalid),
        .mem_rsp_i       (mem_rsp),
        .instr_rvalid_o  (instr_rvalid_o),
        .instr_rsp_o     (instr_rsp_o),
        .data_rvalid_o   (data_rvalid_o),
        .data_rsp_o      (data_rsp_o)
    );

    obi_pma_check u_pma_check (
        .mem_req_i       (mem_req),
        .mem_req_valid_i (mem_req_valid),
        .pma_ok_o        (pma_ok)
    );

    obi_sram u_sram (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .mem_req_i       (mem_req),
        .mem_req_valid_i (mem_req_valid),
        .pma_ok_i        (pma_ok),
        .mem_rvalid_o    (mem_rvalid),
        .mem_rsp_o       (mem_rsp)
    );

endmodule : obi_mem_subsys

`default_nettype wire

//--- verification/obi_mem_subsys_sva.sv
// Concurrent assertions on OBI handshake and response timing, bound into the subsystem top
`timescale 1ns/100ps
`default_nettype none

module obi_mem_subsys_sva (
    input wire logic clk_i,
    input wire logic rst_n_i,
    input wire logic instr_req_i,
    input wire logic instr_gnt_i,
    input wire logic instr_rvalid_i,
    input wire logic data_req_i,
    input wire logic data_gnt_i,
    input wire logic data_rvalid_i
);

    // ----------------------------------------------------------
    // Address phase
    // ----------------------------------------------------------

    // Single memory, one winner per cycle
    a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(instr_gnt_i && data_gnt_i))
        else $error("both ports granted in the same cycle");

    // Memory never stalls
    a_gnt_on_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (instr_req_i || data_req_i) |-> (instr_gnt_i || data_gnt_i))
        else $error("request pending with no grant");

    a_instr_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_gnt_i |-> instr_req_i)
        else $error("instruction grant without request");

    a_data_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_gnt_i |-> data_req_i)
        else $error("data grant without request");

    // ----------------------------------------------------------
    // Response phase
    // ----------------------------------------------------------

    // Exactly one cycle later, on the granted port only
    a_instr_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_gnt_i |=> instr_rvalid_i && !data_rvalid_i)
        else $error("instruction grant not answered on its own port");

    a_data_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_gnt_i |=> data_rvalid_i && !instr_rvalid_i)
        else $error("data grant not answered on its own port");

    a_instr_rvalid_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_rvalid_i |-> $past(instr_gnt_i))
        else $error("instruction rvalid without a grant before it");

    a_data_rvalid_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_rvalid_i |-> $past(data_gnt_i))
        else $error("data rvalid without a grant before it");

    // Outputs quiet while reset is held
    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |-> !(instr_gnt_i || data_gnt_i || instr_rvalid_i || data_rvalid_i))
        else $error("grant or rvalid active during reset");

endmodule : obi_mem_subsys_sva

bind obi_mem_subsys obi_mem_subsys_sva u_sva (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_req_i   (instr_req_i),
    .instr_gnt_i   (instr_gnt_o),
    .instr_rvalid_i(instr_rvalid_o),
    .data_req_i    (data_req_i),
    .data_gnt_i    (data_gnt_o),
    .data_rvalid_i (data_rvalid_o)
);

`default_nettype wire

//--- verification/tb_obi_mem_subsys.sv
// Simulation top that runs a table of OBI accesses through the memory subsystem and checks each response
`timescale 1ns/100ps
`default_nettype none

module tb_obi_mem_subsys
    import obi_mem_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 8;
    // Watchdog budget per table row
    localparam int CYCLES_PER_ROW = 20;

    // One row per test with the ports used, the data request and expected error flags
    typedef struct packed {
        logic              use_instr;
        logic              use_data;
        logic [ADDR_W-1:0] instr_addr;
        logic              instr_err;
        obi_req_t          data_pkt;
        logic              data_err;
    } stim_row_t;

    logic              clk;
    logic              rst_n;
    logic              instr_req;
    logic [ADDR_W-1:0] instr_addr;
    logic              instr_gnt;
    logic              instr_rvalid;
    obi_rsp_t          instr_rsp;
    logic              data_req;
    obi_req_t          data_pkt;
    logic              data_gnt;
    logic              data_rvalid;
    obi_rsp_t          data_rsp;

    stim_row_t         rows[$];
    string             row_names[$];
    // Scoreboard memory keyed by the SRAM word index so aliases land together
    logic [DATA_W-1:0] model_mem [logic [MEM_IDX_W-1:0]];
    // High when data wins the next contested cycle
    logic              prio_data_model;
    int                seed;
    int                error_count;
    int                failed_tests;
    logic              table_ready;

    obi_mem_subsys u_obi_mem_subsys (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .instr_req_i    (instr_req),
        .instr_addr_i   (instr_addr),
        .instr_gnt_o    (instr_gnt),
        .instr_rvalid_o (instr_rvalid),
        .instr_rsp_o    (instr_rsp),
        .data_req_i     (data_req),
        .data_req_pkt_i (data_pkt),
        .data_gnt_o     (data_gnt),
        .data_rvalid_o  (data_rvalid),
        .data_rsp_o     (data_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------

    // Code and data are main and io takes only loads and stores
    function automatic logic region_allows(input logic [ADDR_W-1:0] addr, input logic fetch);
        if (addr <= 32'h0000_1FFF) begin
            return 1'b1;
        end
        if (addr >= 32'h0000_2000 && addr <= 32'h0000_20FF) begin
            return !fetch;
        end
        return 1'b0;
    endfunction

    // Expected response of one access with scoreboard update on allowed writes
    function automatic obi_rsp_t model_access(input obi_req_t req, input logic exp_err);
        logic [MEM_IDX_W-1:0] idx;
        logic [DATA_W-1:0]    word;
        obi_rsp_t             rsp;

        idx       = req.addr[MEM_IDX_W+1:2];
        rsp.err   = exp_err;
        rsp.rdata = '0;
        if (region_allows(req.addr, req.fetch)) begin
            word = model_mem.exists(idx) ? model_mem[idx] : '0;
            if (req.we) begin
                // Byte-lane merge
                for (int b = 0; b < DATA_W / 8; b++) begin
                    if (req.be[b]) begin
                        word[b*8 +: 8] = req.wdata[b*8 +: 8];
                    end
                end
                model_mem[idx] = word;
            end else begin
                rsp.rdata = word;
            end
        end
        return rsp;
    endfunction

    // Expected grant pair where the loser of a contested cycle goes first next time
    task automatic predict_grant(input logic want_i, input logic want_d,
                                 output logic exp_i, output logic exp_d);
        if (want_i && want_d) begin
            exp_d           = prio_data_model;
            exp_i           = !prio_data_model;
            prio_data_model = !prio_data_model;
        end else begin
            exp_i = want_i;
            exp_d = want_d;
        end
    endtask

    // ----------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------

    task automatic check_rsp(input string port, input obi_rsp_t got, input obi_rsp_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s rsp rdata %h err %b, expected rdata %h err %b",
                     $time, port, got.rdata, got.err, exp.rdata, exp.err);
            error_count++;
        end
    endtask

    task automatic check_grant(input logic got_i, input logic got_d,
                               input logic exp_i, input logic exp_d);
        if (got_i !== exp_i || got_d !== exp_d) begin
            $display("MISMATCH at %0t: gnt instr/data %b/%b, expected %b/%b",
                     $time, got_i, got_d, exp_i, exp_d);
            error_count++;
        end
    endtask

    task automatic check_idle(input string when);
        if (instr_gnt !== 1'b0 || data_gnt !== 1'b0 ||
            instr_rvalid !== 1'b0 || data_rvalid !== 1'b0) begin
            $display("ERROR at %0t: a gnt or rvalid output is not low %s", $time, when);
            error_count++;
        end
    endtask

    // Response must sit on the granted port only and one cycle after the grant
    task automatic check_response(input int idx, input logic to_instr, input obi_rsp_t exp_rsp);
        string    port;
        logic     own_valid;
        logic     other_valid;
        obi_rsp_t own_rsp;

        if (to_instr) begin
            port        = "instruction";
            own_valid   = instr_rvalid;
            other_valid = data_rvalid;
            own_rsp     = instr_rsp;
        end else begin
            port        = "data";
            own_valid   = data_rvalid;
            other_valid = instr_rvalid;
            own_rsp     = data_rsp;
        end
        if (own_valid !== 1'b1) begin
            $display("ERROR at %0t: test %0d got no %s response one cycle after its grant",
                     $time, idx, port);
            error_count++;
        end else begin
            check_rsp(port, own_rsp, exp_rsp);
        end
        if (other_valid !== 1'b0) begin
            $display("ERROR at %0t: test %0d saw rvalid on the port that was not granted",
                     $time, idx);
            error_count++;
        end
    endtask

    // ----------------------------------------------------------
    // Table construction
    // ----------------------------------------------------------

    function automatic obi_req_t make_write(input logic [ADDR_W-1:0] addr,
                                            input logic [3:0] be, input logic [DATA_W-1:0] wdata);
        return '{addr: addr, we: 1'b1, be: be, wdata: wdata, fetch: 1'b0};
    endfunction

    function automatic obi_req_t make_read(input logic [ADDR_W-1:0] addr);
        return '{addr: addr, we: 1'b0, be: 4'hF, wdata: '0, fetch: 1'b0};
    endfunction

    task automatic add_both(input string name, input logic [ADDR_W-1:0] iaddr, input logic ierr,
                            input obi_req_t pkt, input logic derr);
        stim_row_t row;

        row = '{use_instr: 1'b1, use_data: 1'b1, instr_addr: iaddr,
                instr_err: ierr, data_pkt: pkt, data_err: derr};
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic add_data(input string name, input obi_req_t pkt, input logic err);
        stim_row_t row;

        row = '{use_instr: 1'b0, use_data: 1'b1, instr_addr: '0,
                instr_err: 1'b0, data_pkt: pkt, data_err: err};
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic add_fetch(input string name, input logic [ADDR_W-1:0] addr, input logic err);
        stim_row_t row;

        row = '{use_instr: 1'b1, use_data: 1'b0, instr_addr: addr,
                instr_err: err, data_pkt: '0, data_err: 1'b0};
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic build_table();
        obi_req_t pkt;

        // Full words first in the data region so partial writes merge into known bytes
        add_data("data wr 0x1000", make_write(32'h1000, 4'hF, $random(seed)), 1'b0);
        add_data("data wr 0x1004", make_write(32'h1004, 4'hF, $random(seed)), 1'b0);
        add_data("data wr be 0011", make_write(32'h1000, 4'h3, $random(seed)), 1'b0);
        add_data("data wr be 1001", make_write(32'h1004, 4'h9, $random(seed)), 1'b0);
        add_data("data wr be 0100", make_write(32'h1000, 4'h4, $random(seed)), 1'b0);
        add_data("data rd 0x1000", make_read(32'h1000), 1'b0);
        add_data("data rd 0x1004", make_read(32'h1004), 1'b0);
        add_data("data wr top 0x1ffc", make_write(32'h1FFC, 4'hF, $random(seed)), 1'b0);
        add_data("data rd top 0x1ffc", make_read(32'h1FFC), 1'b0);
        // Code written by the data port and read back by fetch
        add_data("data wr code 0x0040", make_write(32'h0040, 4'hF, $random(seed)), 1'b0);
        add_fetch("fetch code 0x0040", 32'h0040, 1'b0);
        add_data("data wr code 0x0ffc", make_write(32'h0FFC, 4'hF, $random(seed)), 1'b0);
        add_fetch("fetch code 0x0ffc", 32'h0FFC, 1'b0);
        // io is fine for loads and stores
        add_data("data wr io 0x2000", make_write(32'h2000, 4'hF, $random(seed)), 1'b0);
        add_data("data wr io 0x20fc", make_write(32'h20FC, 4'hF, $random(seed)), 1'b0);
        // Fetch bit on the data port has no effect
        pkt       = make_read(32'h2000);
        pkt.fetch = 1'b1;
        add_data("data rd io fetch bit", pkt, 1'b0);
        add_data("data rd io 0x20fc", make_read(32'h20FC), 1'b0);
        // Denied accesses with their aliases checked afterwards
        add_fetch("fetch io 0x2000", 32'h2000, 1'b1);
        add_fetch("fetch unmapped 0x8000", 32'h8000, 1'b1);
        add_data("data wr unmapped 0x5004", make_write(32'h5004, 4'hF, $random(seed)), 1'b1);
        add_data("data rd alias 0x1004", make_read(32'h1004), 1'b0);
        add_data("data wr unmapped 0x4040", make_write(32'h4040, 4'hF, $random(seed)), 1'b1);
        add_fetch("fetch alias 0x0040", 32'h0040, 1'b0);
        add_data("data rd unmapped 0x2100", make_read(32'h2100), 1'b1);
        add_data("data rd unmapped 0x10000", make_read(32'h1_0000), 1'b1);
        // Contested cycles with data first after reset
        add_both("both wr 0x1008 / fetch", 32'h0040, 1'b0,
                 make_write(32'h1008, 4'hF, $random(seed)), 1'b0);
        add_both("both rd 0x1008 / fetch", 32'h0FFC, 1'b0, make_read(32'h1008), 1'b0);
        add_both("both same word 0x1008", 32'h1008, 1'b0,
                 make_write(32'h1008, 4'h2, $random(seed)), 1'b0);
        add_both("both rd / fetch io", 32'h2000, 1'b1, make_read(32'h1008), 1'b0);
        add_both("both rd 0x1004 / fetch", 32'h1FFC, 1'b0, make_read(32'h1004), 1'b0);
    endtask

    // ----------------------------------------------------------
    // Row execution
    // ----------------------------------------------------------

    // Starts and ends on a falling edge so rows run back to back
    task automatic run_row(input int idx);
        stim_row_t row;
        obi_req_t  req;
        obi_rsp_t  exp_rsp;
        logic      want_instr;
        logic      want_data;
        logic      exp_instr;
        logic      exp_data;
        logic      took_instr;

        row        = rows[idx];
        want_instr = row.use_instr;
        want_data  = row.use_data;
        while (want_instr || want_data) begin
            // Loser of a contested cycle keeps its request up
            instr_req  = want_instr;
            instr_addr = row.instr_addr;
            data_req   = want_data;
            data_pkt   = row.data_pkt;
            // Let the combinational grant settle
            #1;
            if (instr_gnt !== 1'b1 && data_gnt !== 1'b1) begin
                $display("ERROR at %0t: test %0d requested but no port was granted",
                         $time, idx);
                error_count++;
                want_instr = 1'b0;
                want_data  = 1'b0;
                @(negedge clk);
            end else begin
                predict_grant(want_instr, want_data, exp_instr, exp_data);
                check_grant(instr_gnt, data_gnt, exp_instr, exp_data);
                // Scoreboard follows the predicted winner
                took_instr = exp_instr;
                if (took_instr) begin
                    req        = make_read(row.instr_addr);
                    req.fetch  = 1'b1;
                    exp_rsp    = model_access(req, row.instr_err);
                    want_instr = 1'b0;
                end else begin
                    req       = row.data_pkt;
                    req.fetch = 1'b0;
                    exp_rsp   = model_access(req, row.data_err);
                    want_data = 1'b0;
                end
                // Response is due once the grant edge has passed
                @(negedge clk);
                check_response(idx + 1, took_instr, exp_rsp);
            end
        end
        instr_req = 1'b0;
        data_req  = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (error_count == errs_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: FAILED", num, name);
            failed_tests++;
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------

    initial begin
        int errs_before;

        clk             = 1'b0;
        rst_n           = 1'b0;
        instr_req       = 1'b0;
        instr_addr      = '0;
        data_req        = 1'b0;
        data_pkt        = '0;
        seed            = 32'hd9fa_4410;
        error_count     = 0;
        failed_tests    = 0;
        prio_data_model = 1'b1;
        table_ready     = 1'b0;
        build_table();
        table_ready = 1'b1;

        // Quiet outputs through reset and the cycle after
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle("during reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_idle("in the first cycle after reset");
        report_test(0, "reset", 0);

        for (int i = 0; i < rows.size(); i++) begin
            errs_before = error_count;
            run_row(i);
            report_test(i + 1, row_names[i], errs_before);
        end

        $display("tests run %0d, tests failed %0d, errors %0d",
                 rows.size() + 1, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #((RESET_CYCLES + 1 + rows.size() * CYCLES_PER_ROW) * CLK_PERIOD);
        $display("ERROR at %0t: watchdog expired before all tests finished", $time);
        $display("Simulation failed");
        $finish;
    end

endmodule : tb_obi_mem_subsys

`default_nettype wire

//--- build.f
source/obi_mem_pkg.sv
source/obi_port_arbiter.sv
source/obi_pma_check.sv
source/obi_sram.sv
source/obi_mem_subsys.sv
verification/obi_mem_subsys_sva.sv
verification/tb_obi_mem_subsys.sv

//--- Makefile
# Verilator simulation of the OBI memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_obi_mem_subsys
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation failed

.PHONY: sim clean

# Build, run, then search the log for the failure line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "$(TOP): failure found, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
